// File: game_cfg.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Download offsets, video timing and CPU memory map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef GAME_CFG_SVH
`define GAME_CFG_SVH

// Region bounds inside the download stream
`define SCR_START     22'h01_0000
`define OBJ_START     22'h01_8000
`define PROM_START    22'h02_0000

// Video timing in pixels, lines and clk cycles per pixel
`define H_TOTAL       64
`define H_ACTIVE      48
`define H_SYNC_START  52
`define H_SYNC_END    56
`define V_TOTAL       40
`define V_ACTIVE      32
`define V_SYNC_START  34
`define V_SYNC_END    36
`define PXL_DIV       4

// CPU map, tile RAM starts at the bottom of the space
`define ADDR_VRAM_END 11'h0FF
`define ADDR_VSCR     11'h100
`define ADDR_VSCR_END 11'h11F
`define ADDR_DIP      11'h180
`define ADDR_DIP_END  11'h182
`define ADDR_CTRL     11'h1C0
`define ADDR_ACK      11'h1C1

`endif

// File: game_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types: download regions, CPU bus targets
// and tile renderer states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package game_pkg;

    // Where a download byte ends up
    typedef enum logic [1:0] {
        region_main,
        region_scr,
        region_obj,
        region_prom
    } dl_region_t;

    // Target of one CPU access
    typedef enum logic [2:0] {
        sel_none,
        sel_vram,
        sel_vscr,
        sel_dip,
        sel_ctrl,
        sel_ack
    } bus_sel_t;

    // Tile fetch FSM
    typedef enum logic [1:0] {
        rs_idle,
        rs_code,
        rs_fetch,
        rs_wait
    } render_state_t;

endpackage

// File: game_stimulus.txt
// Columns: op addr data expect flag (hex). op 1 download (expect = prog_addr, flag = PROM),
// 2 CPU write, 3 CPU read, 4 set DIP, 5 IRQ frame (data = ctrl), 6 video frame, 7 fill, 0 end
1 000123 11 000123 0
1 00ffff 22 00ffff 0
1 010005 33 01000b 0
1 01234c 44 012348 0
1 017fff 55 017ffe 0
1 018037 66 01803d 0
1 01a0c8 77 01a0c2 0
1 020000 23 020000 1
1 020001 01 020001 1
1 02004e 5c 02004e 1
1 02004f 0a 02004f 1
7 0 0 0 0
2 000 12 0 0
2 0ff e7 0 0
2 045 3c 0 0
2 100 08 0 0
2 11f 55 0 0
2 103 10 0 0
3 000 0 12 0
3 0ff 0 e7 0
3 045 0 3c 0
3 100 0 08 0
3 11f 0 55 0
3 103 0 10 0
4 0 a5c3e 0 0
3 180 0 3e 0
3 181 0 5c 0
3 182 0 fa 0
5 0 84 1 0
5 0 04 0 0
6 0 0 0 0
2 1c0 05 0 0
6 0 0 0 0
0 0 0 0 0

// File: game_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench: stimulus records, CPU and download driver,
// tile ROM model, interrupt and video checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "game_cfg.svh"

module game_tb;

    localparam int REC_WORDS  = 5;
    localparam int MAX_RECS   = 64;
    localparam int FRAME_CLKS = `H_TOTAL * `V_TOTAL * `PXL_DIV;

    logic        clk;
    logic        rst;
    logic [21:0] ioctl_addr;
    logic [ 7:0] ioctl_dout;
    logic        ioctl_wr;
    logic [21:0] prog_addr;
    logic [ 7:0] prog_data;
    logic        prog_we;
    logic        prom_we;
    logic        cpu_cs;
    logic [10:0] cpu_addr;
    logic        cpu_rnw;
    logic [ 7:0] cpu_dout;
    logic [ 7:0] cpu_din;
    logic        irq_n;
    logic [19:0] dipsw;
    logic        scr_cs;
    logic [12:0] scr_addr;
    logic [31:0] scr_data;
    logic        scr_ok;
    logic        pxl_cen;
    logic        LHBL;
    logic        LVBL;
    logic        HS;
    logic        VS;
    logic        V16;
    logic [ 3:0] red;
    logic [ 3:0] green;
    logic [ 3:0] blue;
    logic [11:0] rgb;

    // Stimulus records and reference state
    logic [31:0] stim [0:REC_WORDS*MAX_RECS-1];
    logic [ 7:0] vram_model [0:255];
    logic [ 7:0] vscr_model [0:31];
    logic [11:0] pal_model [0:127];
    logic [12:0] fetch_log [$];
    logic [ 2:0] pal_cur;
    logic [ 7:0] h_cnt;
    logic [ 7:0] v_cnt;
    logic        vis_prev;
    logic        video_on;
    logic        found;
    logic [ 8:0] col_sum;
    logic [12:0] addr_exp;
    logic [11:0] px_exp;
    int          errors;
    int          checks;
    int          good_px;
    int          seed_val;

    tb_clock u_clk (.clk(clk));

    game_top uut (.*);

    assign rgb = {blue, green, red};

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic download(input logic [21:0] addr, input logic [7:0] data,
                            input logic [21:0] exp_addr, input logic is_prom);
        logic [21:0] off;
        @(posedge clk);
        ioctl_wr   <= 1'b1;
        ioctl_addr <= addr;
        ioctl_dout <= data;
        @(posedge clk);
        ioctl_wr <= 1'b0;
        @(negedge clk);
        check_value("prog_addr", prog_addr, exp_addr);
        check_value("prog_data", prog_data, data);
        check_value("prog_we", prog_we, !is_prom);
        check_value("prom_we", prom_we, is_prom);
        // Strobes last a single cycle
        @(negedge clk);
        check_value("prog_we", prog_we, 0);
        check_value("prom_we", prom_we, 0);
        if (addr >= `PROM_START) begin
            off = addr - `PROM_START;
            if (off[0])
                pal_model[off[7:1]][11:8] = data[3:0];
            else
                pal_model[off[7:1]][7:0] = data;
        end
    endtask

    task automatic cpu_write(input logic [10:0] addr, input logic [7:0] data);
        @(posedge clk);
        cpu_cs   <= 1'b1;
        cpu_rnw  <= 1'b0;
        cpu_addr <= addr;
        cpu_dout <= data;
        @(posedge clk);
        cpu_cs  <= 1'b0;
        cpu_rnw <= 1'b1;
        if (addr <= `ADDR_VRAM_END)
            vram_model[addr[7:0]] = data;
        else if (addr >= `ADDR_VSCR && addr <= `ADDR_VSCR_END)
            vscr_model[addr[4:0]] = data;
        else if (addr == `ADDR_CTRL)
            pal_cur = data[3:1];
    endtask

    // Read data shows up one cycle after the access
    task automatic cpu_read(input logic [10:0] addr, input logic [7:0] exp);
        @(posedge clk);
        cpu_cs   <= 1'b1;
        cpu_rnw  <= 1'b1;
        cpu_addr <= addr;
        @(posedge clk);
        cpu_cs <= 1'b0;
        @(negedge clk);
        check_value("cpu_din", cpu_din, exp);
    endtask

    task automatic fill_rams();
        for (int i = 0; i < 256; i++)
            cpu_write(11'(i), 8'(i * 37 + 11));
        for (int i = 0; i < 32; i++)
            cpu_write(11'(`ADDR_VSCR + i), 8'(i * 13 + 5));
    endtask

    task automatic irq_check(input logic [7:0] ctrl, input logic expect_irq);
        int n;
        cpu_write(`ADDR_CTRL, ctrl);
        n = 0;
        if (expect_irq) begin
            while (irq_n !== 1'b0 && n < 2 * FRAME_CLKS) begin
                @(negedge clk);
                n++;
            end
            if (irq_n !== 1'b0) begin
                errors++;
                $display("Timeout: irq_n never went low with the interrupt enabled");
            end else begin
                check_value("LVBL", LVBL, 0);
            end
            cpu_write(`ADDR_ACK, 8'h00);
            @(negedge clk);
            check_value("irq_n", irq_n, 1);
        end else begin
            // A whole frame with no interrupt
            while (irq_n === 1'b1 && n < FRAME_CLKS + 64) begin
                @(negedge clk);
                n++;
            end
            check_value("irq_n", irq_n, 1);
        end
    endtask

    task automatic watch_frame();
        good_px = 0;
        fetch_log.delete();
        video_on = 1'b1;
        for (int n = 0; n < FRAME_CLKS + 256; n++)
            @(negedge clk);
        video_on = 1'b0;
        if (fetch_log.size() == 0) begin
            errors++;
            $display("No tile fetch completed on the ROM port during the frame");
        end
        if (good_px == 0) begin
            errors++;
            $display("No active pixel showed tile data during the frame");
        end
    endtask

    // Tile ROM, every row reads as pixel 7, with random stalls
    always @(posedge clk) begin
        if (rst)
            scr_ok <= 1'b0;
        else
            scr_ok <= scr_cs && !scr_ok && ($urandom % 4 != 0);
    end

    always @(negedge clk) begin
        if (video_on) begin
            // Timing outputs against the reference counters
            check_value("LHBL", LHBL, h_cnt < 8'(`H_ACTIVE));
            check_value("LVBL", LVBL, v_cnt < 8'(`V_ACTIVE));
            check_value("HS", HS,
                        h_cnt >= 8'(`H_SYNC_START) && h_cnt < 8'(`H_SYNC_END));
            check_value("VS", VS,
                        v_cnt >= 8'(`V_SYNC_START) && v_cnt < 8'(`V_SYNC_END));
            check_value("V16", V16, v_cnt[4]);
            if (!vis_prev) begin
                check_value("rgb", rgb, 0);
            end else begin
                px_exp = (rgb == pal_model[0]) ? pal_model[0] : pal_model[{pal_cur, 4'd7}];
                if (rgb == pal_model[{pal_cur, 4'd7}])
                    good_px++;
                check_value("rgb", rgb, px_exp);
            end
            if (scr_cs && scr_ok) begin
                fetch_log.push_back(scr_addr);
                found = 1'b0;
                for (int c = 0; c < 32; c++)
                    if (scr_addr == {2'b00, vram_model[{v_cnt[4:2], 5'(c)}], v_cnt[2:0]})
                        found = 1'b1;
                // Column ahead of the current one, shifted by the row scroll
                col_sum  = {1'b0, h_cnt & 8'hf8} + 9'd8 + {1'b0, vscr_model[v_cnt[4:2]]};
                addr_exp = {2'b00, vram_model[{v_cnt[4:2], col_sum[7:3]}], v_cnt[2:0]};
                check_value("scr_addr", scr_addr, found ? scr_addr : addr_exp);
            end
        end
        vis_prev = LHBL && LVBL;
        if (rst) begin
            h_cnt = 8'd0;
            v_cnt = 8'd0;
        end else if (pxl_cen) begin
            if (h_cnt == 8'(`H_TOTAL - 1)) begin
                h_cnt = 8'd0;
                v_cnt = (v_cnt == 8'(`V_TOTAL - 1)) ? 8'd0 : v_cnt + 8'd1;
            end else begin
                h_cnt = h_cnt + 8'd1;
            end
        end
    end

    initial begin
        int          r;
        logic [31:0] op;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        logic [31:0] f;
        logic        done;
        seed_val   = $urandom(32'h9e0b);
        errors     = 0;
        checks     = 0;
        video_on   = 1'b0;
        vis_prev   = 1'b0;
        pal_cur    = 3'd0;
        rst        = 1'b1;
        ioctl_addr = 22'd0;
        ioctl_dout = 8'd0;
        ioctl_wr   = 1'b0;
        cpu_cs     = 1'b0;
        cpu_addr   = 11'd0;
        cpu_rnw    = 1'b1;
        cpu_dout   = 8'd0;
        dipsw      = 20'd0;
        scr_data   = 32'h7777_7777;
        scr_ok     = 1'b0;
        for (r = 0; r < REC_WORDS * MAX_RECS; r++)
            stim[r] = 32'hffff_ffff;
        $readmemh("game_stimulus.txt", stim);
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        done = 1'b0;
        for (r = 0; r < MAX_RECS && !done; r++) begin
            op = stim[r * REC_WORDS];
            a  = stim[r * REC_WORDS + 1];
            d  = stim[r * REC_WORDS + 2];
            e  = stim[r * REC_WORDS + 3];
            f  = stim[r * REC_WORDS + 4];
            case (op)
                0: done = 1'b1;
                1: download(a[21:0], d[7:0], e[21:0], f[0]);
                2: cpu_write(a[10:0], d[7:0]);
                3: cpu_read(a[10:0], e[7:0]);
                4: begin
                    @(posedge clk);
                    dipsw <= d[19:0];
                end
                5: irq_check(d[7:0], e[0]);
                6: watch_frame();
                7: fill_rams();
                default: begin
                    errors++;
                    $display("Stimulus record %0d holds an unknown opcode %0h", r, op);
                    done = 1'b1;
                end
            endcase
        end
        if (!done) begin
            errors++;
            $display("Stimulus file has no end record");
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: game_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Game subsystem top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module game_top (
    input  logic        clk,
    input  logic        rst,
    // download
    input  logic [21:0] ioctl_addr,
    input  logic [ 7:0] ioctl_dout,
    input  logic        ioctl_wr,
    output logic [21:0] prog_addr,
    output logic [ 7:0] prog_data,
    output logic        prog_we,
    output logic        prom_we,
    // CPU bus
    input  logic        cpu_cs,
    input  logic [10:0] cpu_addr,
    input  logic        cpu_rnw,
    input  logic [ 7:0] cpu_dout,
    output logic [ 7:0] cpu_din,
    output logic        irq_n,
    input  logic [19:0] dipsw,
    // Tile ROM
    output logic        scr_cs,
    output logic [12:0] scr_addr,
    input  logic [31:0] scr_data,
    input  logic        scr_ok,
    // video
    output logic        pxl_cen,
    output logic        LHBL,
    output logic        LVBL,
    output logic        HS,
    output logic        VS,
    output logic        V16,
    output logic [ 3:0] red,
    output logic [ 3:0] green,
    output logic [ 3:0] blue
);

    logic [7:0] hpos, vpos, prom_addr;
    logic [2:0] pal_sel;
    logic       flip;

    gfx_bus_if u_gfx();

    prog_remap u_remap (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .ioctl_addr ( ioctl_addr ),
        .ioctl_dout ( ioctl_dout ),
        .ioctl_wr   ( ioctl_wr   ),
        .prog_addr  ( prog_addr  ),
        .prog_data  ( prog_data  ),
        .prog_we    ( prog_we    ),
        .prom_we    ( prom_we    ),
        .prom_addr  ( prom_addr  )
    );

    video_timer u_timer (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .pxl_cen ( pxl_cen ),
        .hpos    ( hpos    ),
        .vpos    ( vpos    ),
        .LHBL    ( LHBL    ),
        .LVBL    ( LVBL    ),
        .HS      ( HS      ),
        .VS      ( VS      ),
        .V16     ( V16     )
    );

    main_bus u_main (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .cpu_cs   ( cpu_cs   ),
        .cpu_addr ( cpu_addr ),
        .cpu_rnw  ( cpu_rnw  ),
        .cpu_dout ( cpu_dout ),
        .dipsw    ( dipsw    ),
        .LVBL     ( LVBL     ),
        .cpu_din  ( cpu_din  ),
        .irq_n    ( irq_n    ),
        .flip     ( flip     ),
        .pal_sel  ( pal_sel  ),
        .gfx      ( u_gfx    )
    );

    scroll_render u_video (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .pxl_cen   ( pxl_cen   ),
        .hpos      ( hpos      ),
        .vpos      ( vpos      ),
        .LHBL      ( LHBL      ),
        .LVBL      ( LVBL      ),
        .pal_sel   ( pal_sel   ),
        .flip      ( flip      ),
        .scr_data  ( scr_data  ),
        .scr_ok    ( scr_ok    ),
        .prom_we   ( prom_we   ),
        .prom_addr ( prom_addr ),
        .prog_data ( prog_data ),
        .scr_cs    ( scr_cs    ),
        .scr_addr  ( scr_addr  ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      ),
        .bus       ( u_gfx     )
    );

endmodule

// File: gfx_bus_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU access path into the tile and scroll RAMs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface gfx_bus_if;
    logic [10:0] addr;
    logic [ 7:0] dout;
    logic        rnw;
    logic        vram_cs;
    logic        vscr_cs;
    // Read data, one cycle after the select
    logic [ 7:0] vram_dout;
    logic [ 7:0] vscr_dout;

    modport cpu (
        output addr, dout, rnw, vram_cs, vscr_cs,
        input  vram_dout, vscr_dout
    );

    modport gfx (
        input  addr, dout, rnw, vram_cs, vscr_cs,
        output vram_dout, vscr_dout
    );
endinterface

// File: main_bus.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU decoder, read mux, DIP reads, control latch, IRQ
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "game_cfg.svh"

module main_bus import game_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cpu_cs,
    input  logic [10:0] cpu_addr,
    input  logic        cpu_rnw,
    input  logic [ 7:0] cpu_dout,
    input  logic [19:0] dipsw,
    input  logic        LVBL,
    output logic [ 7:0] cpu_din,
    output logic        irq_n,
    output logic        flip,
    output logic [ 2:0] pal_sel,
    gfx_bus_if.cpu      gfx
);

    bus_sel_t   sel;
    bus_sel_t   rd_sel;
    logic [7:0] dip_q;
    logic       irq_en;
    logic       lvbl_l;
    logic       wr;

    always_comb begin
        sel = sel_none;
        if (cpu_addr <= `ADDR_VRAM_END) sel = sel_vram;
        else if (cpu_addr >= `ADDR_VSCR && cpu_addr <= `ADDR_VSCR_END) sel = sel_vscr;
        else if (cpu_addr >= `ADDR_DIP && cpu_addr <= `ADDR_DIP_END) sel = sel_dip;
        else if (cpu_addr == `ADDR_CTRL) sel = sel_ctrl;
        else if (cpu_addr == `ADDR_ACK) sel = sel_ack;
    end

    assign wr = cpu_cs && !cpu_rnw;

    // RAM accesses go straight through to the renderer
    assign gfx.addr    = cpu_addr;
    assign gfx.dout    = cpu_dout;
    assign gfx.rnw     = cpu_rnw;
    assign gfx.vram_cs = cpu_cs && sel == sel_vram;
    assign gfx.vscr_cs = cpu_cs && sel == sel_vscr;

    always_ff @(posedge clk) begin
        if (rst) rd_sel <= sel_none;
        else rd_sel <= (cpu_cs && cpu_rnw) ? sel : sel_none;
    end

    // Upper nibble of the third DIP byte reads as ones
    always_ff @(posedge clk) begin
        case (cpu_addr[1:0])
            2'd0:    dip_q <= dipsw[7:0];
            2'd1:    dip_q <= dipsw[15:8];
            default: dip_q <= {4'hf, dipsw[19:16]};
        endcase
    end

    always_comb begin
        case (rd_sel)
            sel_vram: cpu_din = gfx.vram_dout;
            sel_vscr: cpu_din = gfx.vscr_dout;
            sel_dip:  cpu_din = dip_q;
            sel_ctrl: cpu_din = {irq_en, 3'd0, pal_sel, flip};
            default:  cpu_din = 8'hff;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flip    <= 1'b0;
            pal_sel <= 3'd0;
            irq_en  <= 1'b0;
            irq_n   <= 1'b1;
            lvbl_l  <= 1'b0;
        end else begin
            lvbl_l <= LVBL;
            if (wr && sel == sel_ctrl) begin
                flip    <= cpu_dout[0];
                pal_sel <= cpu_dout[3:1];
                irq_en  <= cpu_dout[7];
            end
            if (wr && sel == sel_ack) irq_n <= 1'b1;
            // a new vblank wins over a same-cycle ack
            if (irq_en && lvbl_l && !LVBL) irq_n <= 1'b0;
        end
    end

endmodule

// File: prog_remap.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Download region decode and gfx address scrambling
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "game_cfg.svh"

module prog_remap import game_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [21:0] ioctl_addr,
    input  logic [ 7:0] ioctl_dout,
    input  logic        ioctl_wr,
    output logic [21:0] prog_addr,
    output logic [ 7:0] prog_data,
    output logic        prog_we,
    output logic        prom_we,
    output logic [ 7:0] prom_addr
);

    dl_region_t  region;
    logic [21:0] post_addr;
    logic [21:0] prom_off;

    always_comb begin
        if (ioctl_addr >= `PROM_START) region = region_prom;
        else if (ioctl_addr >= `OBJ_START) region = region_obj;
        else if (ioctl_addr >= `SCR_START) region = region_scr;
        else region = region_main;
    end

    // Bit order the renderer expects for each graphics set
    always_comb begin
        post_addr = ioctl_addr;
        case (region)
            region_scr: begin
                post_addr[0]   = ~ioctl_addr[3];
                post_addr[3:1] = ioctl_addr[2:0];
            end
            region_obj: begin
                post_addr[0]   = ~ioctl_addr[3];
                post_addr[1]   = ~ioctl_addr[4];
                post_addr[5:2] = {ioctl_addr[5], ioctl_addr[2:0]};
            end
            default: post_addr = ioctl_addr;
        endcase
    end

    assign prom_off = ioctl_addr - `PROM_START;

    always_ff @(posedge clk) begin
        if (rst) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prog_we <= ioctl_wr && region != region_prom;
            prom_we <= ioctl_wr && region == region_prom;
        end
    end

    always_ff @(posedge clk) begin
        prog_addr <= post_addr;
        prog_data <= ioctl_dout;
        prom_addr <= prom_off[7:0];
    end

endmodule

// File: project.f
+incdir+.
game_pkg.sv
gfx_bus_if.sv
prog_remap.sv
video_timer.sv
main_bus.sv
scroll_render.sv
game_top.sv
tb_clock.sv
game_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the game subsystem testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f project.f --top-module game_tb -o game_sim \
    && ./obj_dir/game_sim | tee /dev/stderr | grep -q "^TEST RESULT: PASS$" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: scroll_render.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scroll tilemap with tile fetch FSM and palette PROM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module scroll_render import game_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        pxl_cen,
    input  logic [ 7:0] hpos,
    input  logic [ 7:0] vpos,
    input  logic        LHBL,
    input  logic        LVBL,
    input  logic [ 2:0] pal_sel,
    input  logic        flip,
    input  logic [31:0] scr_data,
    input  logic        scr_ok,
    input  logic        prom_we,
    input  logic [ 7:0] prom_addr,
    input  logic [ 7:0] prog_data,
    output logic        scr_cs,
    output logic [12:0] scr_addr,
    output logic [ 3:0] red,
    output logic [ 3:0] green,
    output logic [ 3:0] blue,
    gfx_bus_if.gfx      bus
);

    logic [ 7:0] vram [0:255];
    logic [ 7:0] vscr [0:31];
    logic [11:0] pal_mem [0:127];

    render_state_t st;
    logic [ 2:0] row;
    logic [ 7:0] scroll;
    logic [ 8:0] col_sum;
    logic [ 7:0] code;
    logic [31:0] nxt_data;
    logic [31:0] cur_data;
    logic        nxt_ok;
    logic        cur_ok;
    logic        want;
    logic        late;
    logic        col_end;
    logic [ 2:0] nib_sel;
    logic [ 3:0] nib;
    logic [ 6:0] pal_idx;

    // CPU side of the two RAMs
    always_ff @(posedge clk) begin
        if (bus.vram_cs && !bus.rnw) vram[bus.addr[7:0]] <= bus.dout;
        if (bus.vscr_cs && !bus.rnw) vscr[bus.addr[4:0]] <= bus.dout;
        bus.vram_dout <= vram[bus.addr[7:0]];
        bus.vscr_dout <= vscr[bus.addr[4:0]];
    end

    // Two download bytes per entry, low byte first
    always_ff @(posedge clk) begin
        if (prom_we) begin
            if (prom_addr[0]) pal_mem[prom_addr[7:1]][11:8] <= prog_data[3:0];
            else pal_mem[prom_addr[7:1]][7:0] <= prog_data;
        end
    end

    assign row     = vpos[4:2];
    assign scroll  = vscr[{2'b00, row}];
    assign col_sum = {1'b0, hpos} + 9'd8 + {1'b0, scroll};
    assign col_end = pxl_cen && hpos[2:0] == 3'd7;

    // Fetch runs one column ahead; data that misses the column edge is dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            st     <= rs_idle;
            scr_cs <= 1'b0;
            want   <= 1'b0;
            late   <= 1'b0;
            nxt_ok <= 1'b0;
            cur_ok <= 1'b0;
        end else begin
            if (col_end) begin
                cur_data <= nxt_data;
                cur_ok   <= nxt_ok;
                nxt_ok   <= 1'b0;
                want     <= 1'b1;
                late     <= st != rs_idle;
            end
            case (st)
                rs_idle: if (want || col_end) begin
                    want <= 1'b0;
                    st   <= rs_code;
                end
                rs_code: begin
                    code <= vram[{row, col_sum[7:3]}];
                    st   <= rs_fetch;
                end
                rs_fetch: begin
                    scr_addr <= {2'b00, code, vpos[2:0]};
                    scr_cs   <= 1'b1;
                    st       <= rs_wait;
                end
                rs_wait: if (scr_ok) begin
                    scr_cs <= 1'b0;
                    st     <= rs_idle;
                    if (!late && !col_end) begin
                        nxt_data <= scr_data;
                        nxt_ok   <= 1'b1;
                    end
                end
            endcase
        end
    end

    // Lowest nibble is the first pixel unless flipped
    assign nib_sel = hpos[2:0] ^ {3{flip}};
    assign nib     = cur_data[{nib_sel, 2'b00} +: 4];
    assign pal_idx = cur_ok ? {pal_sel, nib} : 7'd0;

    always_ff @(posedge clk) begin
        if (rst) begin
            {blue, green, red} <= 12'd0;
        end else if (LHBL && LVBL) begin
            {blue, green, red} <= pal_mem[pal_idx];
        end else begin
            {blue, green, red} <= 12'd0;
        end
    end

endmodule

// File: tb_clock.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock source, 100 ns period
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_clock #(
    parameter real HALF_PERIOD = 50.0
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(HALF_PERIOD) clk = ~clk;

endmodule

// File: video_timer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pixel enable, counters, blanking and syncs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "game_cfg.svh"

module video_timer (
    input  logic       clk,
    input  logic       rst,
    output logic       pxl_cen,
    output logic [7:0] hpos,
    output logic [7:0] vpos,
    output logic       LHBL,
    output logic       LVBL,
    output logic       HS,
    output logic       VS,
    output logic       V16
);

    localparam int         DW       = $clog2(`PXL_DIV);
    localparam logic [DW-1:0] DIV_LAST = DW'(`PXL_DIV - 1);
    localparam logic [7:0] H_LAST   = 8'(`H_TOTAL - 1);
    localparam logic [7:0] V_LAST   = 8'(`V_TOTAL - 1);
    localparam logic [7:0] H_ACT    = 8'(`H_ACTIVE);
    localparam logic [7:0] V_ACT    = 8'(`V_ACTIVE);
    localparam logic [7:0] HS_ON    = 8'(`H_SYNC_START);
    localparam logic [7:0] HS_OFF   = 8'(`H_SYNC_END);
    localparam logic [7:0] VS_ON    = 8'(`V_SYNC_START);
    localparam logic [7:0] VS_OFF   = 8'(`V_SYNC_END);

    logic [DW-1:0] div_cnt;

    // One enable every PXL_DIV clocks
    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            pxl_cen <= 1'b0;
        end else begin
            pxl_cen <= div_cnt == DIV_LAST;
            div_cnt <= (div_cnt == DIV_LAST) ? '0 : div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hpos <= 8'd0;
            vpos <= 8'd0;
        end else if (pxl_cen) begin
            if (hpos == H_LAST) begin
                hpos <= 8'd0;
                vpos <= (vpos == V_LAST) ? 8'd0 : vpos + 8'd1;
            end else begin
                hpos <= hpos + 8'd1;
            end
        end
    end

    // Decoded straight from the counters so they line up with hpos/vpos
    assign LHBL = hpos < H_ACT;
    assign LVBL = vpos < V_ACT;
    assign HS   = hpos >= HS_ON && hpos < HS_OFF;
    assign VS   = vpos >= VS_ON && vpos < VS_OFF;
    assign V16  = vpos[4];

endmodule
